// File: src/zebra_config.svh
`ifndef ZEBRA_CONFIG_SVH
`define ZEBRA_CONFIG_SVH

// ====================
// Frame geometry
// ====================

// Input frame size in pixels
`define IMG_WIDTH 16
`define IMG_HEIGHT 12

// Pixel and coefficient width
`define PIX_W 8

// Filtered frame loses one pixel on each border
`define OUT_WIDTH (`IMG_WIDTH - 2)
`define OUT_HEIGHT (`IMG_HEIGHT - 2)

// Analysed columns of the filtered frame
`define COL_A (`OUT_WIDTH / 4)
`define COL_B (`OUT_WIDTH / 2)
`define COL_C (`OUT_WIDTH * 3 / 4)

// ====================
// Register reset values
// ====================

`define DEF_SHIFT 3'd2
`define DEF_WHITE_THR 8'd180
`define DEF_BLACK_THR 8'd75
`define DEF_MIN_STRIPE 8'd2
`define DEF_MIN_ALT 8'd3

// Vertical Sobel, row-major
`define DEF_K0 (-8'sd1)
`define DEF_K1 (-8'sd2)
`define DEF_K2 (-8'sd1)
`define DEF_K3 8'sd0
`define DEF_K4 8'sd0
`define DEF_K5 8'sd0
`define DEF_K6 8'sd1
`define DEF_K7 8'sd2
`define DEF_K8 8'sd1

`endif

// File: src/zebra_pkg.sv
package zebra_pkg;

    // Class of the current run in the analysed column
    typedef enum logic [1:0] {
        ST_NONE  = 2'd0,
        ST_WHITE = 2'd1,
        ST_BLACK = 2'd2
    } stripe_state_t;

    // Configuration register map
    // Kernel sits in K0..K8, row-major
    typedef enum logic [3:0] {
        REG_K0         = 4'd0,
        REG_K1         = 4'd1,
        REG_K2         = 4'd2,
        REG_K3         = 4'd3,
        REG_K4         = 4'd4,
        REG_K5         = 4'd5,
        REG_K6         = 4'd6,
        REG_K7         = 4'd7,
        REG_K8         = 4'd8,
        REG_SHIFT      = 4'd9,
        REG_WHITE      = 4'd10,
        REG_BLACK      = 4'd11,
        REG_MIN_STRIPE = 4'd12,
        REG_MIN_ALT    = 4'd13
    } cfg_addr_t;

endpackage

// File: src/detect_config_regs.sv
`timescale 1ns/10ps
`include "zebra_config.svh"

module detect_config_regs
    import zebra_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // Host write strobe
    input  logic                     cfg_we,
    input  cfg_addr_t                cfg_addr,
    input  logic [7:0]               cfg_wdata,
    // Filter settings
    output logic [9*`PIX_W-1:0]      kern_flat,
    output logic [2:0]               shift,
    // Detector settings
    output logic [7:0]               white_thr,
    output logic [7:0]               black_thr,
    output logic [7:0]               min_stripe,
    output logic [7:0]               min_alt
);

    // ====================
    // Register file
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            // Coefficient 0 lives in the low byte
            kern_flat  <= {`DEF_K8, `DEF_K7, `DEF_K6,
                           `DEF_K5, `DEF_K4, `DEF_K3,
                           `DEF_K2, `DEF_K1, `DEF_K0};
            shift      <= `DEF_SHIFT;
            white_thr  <= `DEF_WHITE_THR;
            black_thr  <= `DEF_BLACK_THR;
            min_stripe <= `DEF_MIN_STRIPE;
            min_alt    <= `DEF_MIN_ALT;
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_K0, REG_K1, REG_K2,
                REG_K3, REG_K4, REG_K5,
                REG_K6, REG_K7, REG_K8: begin
                    // Address doubles as coefficient index
                    kern_flat[cfg_addr*`PIX_W +: `PIX_W] <= cfg_wdata;
                end
                REG_SHIFT:      shift      <= cfg_wdata[2:0];
                REG_WHITE:      white_thr  <= cfg_wdata;
                REG_BLACK:      black_thr  <= cfg_wdata;
                REG_MIN_STRIPE: min_stripe <= cfg_wdata;
                REG_MIN_ALT:    min_alt    <= cfg_wdata;
                // Unmapped addresses are dropped
                default: ;
            endcase
        end
    end

endmodule

// File: src/convolution_filter.sv
`timescale 1ns/10ps
`include "zebra_config.svh"

module convolution_filter (
    input  logic                     clk,
    input  logic                     rst,
    // Pixel input stream
    input  logic                     x_valid,
    output logic                     x_ready,
    input  logic [`PIX_W-1:0]        x_data,
    // Filtered output stream
    output logic                     y_valid,
    input  logic                     y_ready,
    output logic [`PIX_W-1:0]        y_data,
    // Kernel and output scaling
    input  logic [9*`PIX_W-1:0]      kern_flat,
    input  logic [2:0]               shift
);

    localparam int CW    = $clog2(`IMG_WIDTH);
    localparam int RW    = $clog2(`IMG_HEIGHT);
    localparam int ACC_W = 2 * `PIX_W + 4;

    logic [CW-1:0]              col;
    logic [RW-1:0]              row;
    logic                       accept;
    logic [`PIX_W-1:0]          lb0 [0:`IMG_WIDTH-1];
    logic [`PIX_W-1:0]          lb1 [0:`IMG_WIDTH-1];
    logic [`PIX_W-1:0]          win [0:8];
    logic                       win_valid;
    logic                       s1_valid;
    logic signed [ACC_W-1:0]    s1_sum;
    logic                       s1_free;
    logic                       s1_take;
    logic                       s2_free;
    logic                       s2_take;
    logic signed [`PIX_W-1:0]   coef;
    logic signed [2*`PIX_W:0]   prod;
    logic signed [ACC_W-1:0]    mac;
    logic [ACC_W-1:0]           abs_val;
    logic [ACC_W-1:0]           shifted;

    // ====================
    // Flow control
    // ====================

    // Output stage empties when the sink takes its pixel
    assign s2_free = !y_valid || y_ready;
    assign s2_take = s1_valid && s2_free;
    assign s1_free = !s1_valid || s2_free;
    assign s1_take = win_valid && s1_free;

    // A pending window must reach stage one before it can be overwritten
    assign x_ready = !win_valid || s1_free;
    assign accept  = x_valid && x_ready;

    // Raster position of the incoming pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (col == CW'(`IMG_WIDTH - 1)) begin
                col <= '0;
                row <= (row == RW'(`IMG_HEIGHT - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ====================
    // Line buffers and window
    // ====================

    // lb1 holds two rows up, lb0 one row up
    always_ff @(posedge clk) begin
        if (accept) begin
            lb1[col] <= lb0[col];
            lb0[col] <= x_data;
            for (int r = 0; r < 3; r++) begin
                win[r*3]     <= win[r*3+1];
                win[r*3+1]   <= win[r*3+2];
            end
            // New right-hand column
            win[2] <= lb1[col];
            win[5] <= lb0[col];
            win[8] <= x_data;
        end
    end

    // Only windows fully inside the frame go on
    always_ff @(posedge clk) begin
        if (rst)
            win_valid <= 1'b0;
        else if (accept)
            win_valid <= (row >= RW'(2)) && (col >= CW'(2));
        else if (s1_take)
            win_valid <= 1'b0;
    end

    // ====================
    // Stage one multiply-accumulate
    // ====================

    always_comb begin
        mac = '0;
        for (int i = 0; i < 9; i++) begin
            coef = kern_flat[i*`PIX_W +: `PIX_W];
            prod = coef * $signed({1'b0, win[i]});
            mac  = mac + ACC_W'(prod);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            s1_valid <= 1'b0;
        else if (s1_take)
            s1_valid <= 1'b1;
        else if (s2_take)
            s1_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (s1_take)
            s1_sum <= mac;
    end

    // ====================
    // Stage two scaling
    // ====================

    // Magnitude, shift down, clip to pixel range
    assign abs_val = s1_sum[ACC_W-1] ? ACC_W'(-s1_sum) : ACC_W'(s1_sum);
    assign shifted = abs_val >> shift;

    always_ff @(posedge clk) begin
        if (rst)
            y_valid <= 1'b0;
        else if (s2_take)
            y_valid <= 1'b1;
        else if (y_ready)
            y_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (s2_take)
            y_data <= (|shifted[ACC_W-1:`PIX_W]) ? '1 : shifted[`PIX_W-1:0];
    end

endmodule

// File: src/zebra_crossing_detector_stream.sv
`timescale 1ns/10ps
`include "zebra_config.svh"

module zebra_crossing_detector_stream
    import zebra_pkg::*;
#(
    parameter int COLUMN = `COL_B
) (
    input  logic          clk,
    input  logic          rst,
    // Tap on the filtered stream
    input  logic          out_fire,
    input  logic [7:0]    pix,
    // Settings
    input  logic [7:0]    white_thr,
    input  logic [7:0]    black_thr,
    input  logic [7:0]    min_stripe,
    input  logic [7:0]    min_alt,
    // Per-frame result
    output logic          result_valid,
    output logic          detected,
    output logic [7:0]    alt_count
);

    localparam int CW = $clog2(`OUT_WIDTH);
    localparam int RW = $clog2(`OUT_HEIGHT);

    logic [CW-1:0]    col;
    logic [RW-1:0]    row;
    logic             col_hit;
    logic             frame_end;
    stripe_state_t    cur_state;
    stripe_state_t    last_stripe;
    stripe_state_t    cls_next;
    logic [7:0]       run_len;
    logic [7:0]       run_next;
    logic [7:0]       alt_run;
    logic [7:0]       alt_next;
    logic [7:0]       alt_final;
    logic             qualify;

    // ====================
    // Position in the filtered frame
    // ====================

    assign col_hit   = out_fire && (col == CW'(COLUMN));
    assign frame_end = out_fire && (col == CW'(`OUT_WIDTH - 1))
                                && (row == RW'(`OUT_HEIGHT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
            row <= '0;
        end else if (out_fire) begin
            if (col == CW'(`OUT_WIDTH - 1)) begin
                col <= '0;
                row <= (row == RW'(`OUT_HEIGHT - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ====================
    // Stripe classifier
    // ====================

    always_comb begin
        // Grey pixels extend the current class
        cls_next = cur_state;
        if (pix >= white_thr)
            cls_next = ST_WHITE;
        else if (pix <= black_thr)
            cls_next = ST_BLACK;
        if (cls_next == cur_state)
            run_next = (run_len == 8'hFF) ? run_len : run_len + 8'd1;
        else
            run_next = 8'd1;
        // Run long enough and of a new class
        qualify = (cls_next != ST_NONE) && (cls_next != last_stripe)
                  && (run_next >= min_stripe);
        // First qualified stripe only arms the count
        alt_next = alt_run;
        if (qualify && (last_stripe != ST_NONE))
            alt_next = alt_run + 8'd1;
        alt_final = col_hit ? alt_next : alt_run;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_state    <= ST_NONE;
            last_stripe  <= ST_NONE;
            run_len      <= '0;
            alt_run      <= '0;
            result_valid <= 1'b0;
            detected     <= 1'b0;
            alt_count    <= '0;
        end else begin
            result_valid <= 1'b0;
            if (frame_end) begin
                // Report and start the next frame clean
                result_valid <= 1'b1;
                detected     <= (alt_final >= min_alt);
                alt_count    <= alt_final;
                cur_state    <= ST_NONE;
                last_stripe  <= ST_NONE;
                run_len      <= '0;
                alt_run      <= '0;
            end else if (col_hit) begin
                cur_state <= cls_next;
                run_len   <= run_next;
                alt_run   <= alt_next;
                if (qualify)
                    last_stripe <= cls_next;
            end
        end
    end

endmodule

// File: src/pattern_recognition.sv
`timescale 1ns/10ps
`include "zebra_config.svh"

module pattern_recognition
    import zebra_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // Camera pixel stream
    input  logic                 x_valid,
    output logic                 x_ready,
    input  logic [`PIX_W-1:0]    x_data,
    // Filtered pixel stream
    output logic                 y_valid,
    input  logic                 y_ready,
    output logic [`PIX_W-1:0]    y_data,
    // Host register writes
    input  logic                 cfg_we,
    input  cfg_addr_t            cfg_addr,
    input  logic [7:0]           cfg_wdata,
    // Frame result
    output logic                 crossing_detected,
    output logic                 detection_valid,
    output logic [7:0]           stripe_count
);

    logic [9*`PIX_W-1:0]  kern_flat;
    logic [2:0]           shift;
    logic [7:0]           white_thr;
    logic [7:0]           black_thr;
    logic [7:0]           min_stripe;
    logic [7:0]           min_alt;
    logic                 out_fire;
    logic                 rv_a, rv_b, rv_c;
    logic                 det_a, det_b, det_c;
    logic [7:0]           alt_a, alt_b, alt_c;
    logic [9:0]           cnt_sum;

    detect_config_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .kern_flat  (kern_flat),
        .shift      (shift),
        .white_thr  (white_thr),
        .black_thr  (black_thr),
        .min_stripe (min_stripe),
        .min_alt    (min_alt)
    );

    convolution_filter u_filter (
        .clk       (clk),
        .rst       (rst),
        .x_valid   (x_valid),
        .x_ready   (x_ready),
        .x_data    (x_data),
        .y_valid   (y_valid),
        .y_ready   (y_ready),
        .y_data    (y_data),
        .kern_flat (kern_flat),
        .shift     (shift)
    );

    // ====================
    // Column detectors
    // ====================

    // Detectors only watch completed output transfers
    assign out_fire = y_valid && y_ready;

    zebra_crossing_detector_stream #(.COLUMN(`COL_A)) u_det_a (
        .clk (clk), .rst (rst), .out_fire (out_fire), .pix (y_data),
        .white_thr (white_thr), .black_thr (black_thr),
        .min_stripe (min_stripe), .min_alt (min_alt),
        .result_valid (rv_a), .detected (det_a), .alt_count (alt_a)
    );

    zebra_crossing_detector_stream #(.COLUMN(`COL_B)) u_det_b (
        .clk (clk), .rst (rst), .out_fire (out_fire), .pix (y_data),
        .white_thr (white_thr), .black_thr (black_thr),
        .min_stripe (min_stripe), .min_alt (min_alt),
        .result_valid (rv_b), .detected (det_b), .alt_count (alt_b)
    );

    zebra_crossing_detector_stream #(.COLUMN(`COL_C)) u_det_c (
        .clk (clk), .rst (rst), .out_fire (out_fire), .pix (y_data),
        .white_thr (white_thr), .black_thr (black_thr),
        .min_stripe (min_stripe), .min_alt (min_alt),
        .result_valid (rv_c), .detected (det_c), .alt_count (alt_c)
    );

    // Pulses line up since all three share the frame counters
    assign detection_valid   = rv_a && rv_b && rv_c;
    // Any column is enough
    assign crossing_detected = det_a || det_b || det_c;
    // Integer mean of the three counts
    assign cnt_sum      = 10'(alt_a) + 10'(alt_b) + 10'(alt_c);
    assign stripe_count = 8'(cnt_sum / 10'd3);

endmodule

// File: test/tb_pattern_recognition.sv
`timescale 1ns/10ps
`include "zebra_config.svh"

module tb_pattern_recognition
    import zebra_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int NPIX         = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int OUT_PIX      = `OUT_WIDTH * `OUT_HEIGHT;
    localparam int NUM_FRAMES   = 6;
    // Four cycles per pixel covers random back-pressure, plus reset and writes
    localparam int WATCH_CYCLES = NUM_FRAMES * NPIX * 4 + 600;

    logic              clk = 1'b0;
    logic              rst;
    logic              x_valid;
    logic              x_ready;
    logic [7:0]        x_data;
    logic              y_valid;
    logic              y_ready;
    logic [7:0]        y_data;
    logic              cfg_we;
    cfg_addr_t         cfg_addr;
    logic [7:0]        cfg_wdata;
    logic              crossing_detected;
    logic              detection_valid;
    logic [7:0]        stripe_count;

    int                errors = 0;
    int                checks = 0;
    logic [31:0]       pix_rng = 32'hb3c8;
    logic [31:0]       rdy_rng = 32'hb3c8 ^ 32'h5a5a_0f0f;
    logic              bp_on = 1'b0;
    logic [7:0]        frame [NPIX];
    int                out_m [OUT_PIX];
    logic [7:0]        got_q [$];
    logic [7:0]        sobel_q [$];
    int                kern_m [9];
    int                sobel_k [9] = '{-1, -2, -1, 0, 0, 0, 1, 2, 1};
    int                cols [3] = '{`COL_A, `COL_B, `COL_C};
    int                shift_m;
    int                white_m;
    int                black_m;
    int                min_stripe_m;
    int                min_alt_m;
    int                exp_cnt;
    logic              exp_det;
    int                zebra_cnt;
    logic              det_seen = 1'b0;
    logic              det_got = 1'b0;
    logic [7:0]        cnt_got = '0;
    logic              stall_q = 1'b0;
    logic [7:0]        held_q = '0;

    pattern_recognition dut (
        .clk               (clk),
        .rst               (rst),
        .x_valid           (x_valid),
        .x_ready           (x_ready),
        .x_data            (x_data),
        .y_valid           (y_valid),
        .y_ready           (y_ready),
        .y_data            (y_data),
        .cfg_we            (cfg_we),
        .cfg_addr          (cfg_addr),
        .cfg_wdata         (cfg_wdata),
        .crossing_detected (crossing_detected),
        .detection_valid   (detection_valid),
        .stripe_count      (stripe_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // Reference model
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Interior windows only, absolute sum, shift, clip at 255
    function automatic void model_filter();
        int acc;
        for (int r = 0; r < `OUT_HEIGHT; r++) begin
            for (int c = 0; c < `OUT_WIDTH; c++) begin
                acc = 0;
                for (int k = 0; k < 9; k++) begin
                    acc += kern_m[k] * int'(frame[(r + k / 3) * `IMG_WIDTH + c + k % 3]);
                end
                if (acc < 0)
                    acc = -acc;
                acc = acc >> shift_m;
                out_m[r * `OUT_WIDTH + c] = (acc > 255) ? 255 : acc;
            end
        end
    endfunction

    // Alternations of qualified stripes down one filtered column
    function automatic int count_alts(input int column);
        stripe_state_t cur;
        stripe_state_t last;
        stripe_state_t cls;
        int            run;
        int            alt;
        int            p;
        cur  = ST_NONE;
        last = ST_NONE;
        run  = 0;
        alt  = 0;
        for (int r = 0; r < `OUT_HEIGHT; r++) begin
            p   = out_m[r * `OUT_WIDTH + column];
            cls = cur;
            if (p >= white_m)
                cls = ST_WHITE;
            else if (p <= black_m)
                cls = ST_BLACK;
            run = (cls == cur) ? run + 1 : 1;
            cur = cls;
            if (cls != ST_NONE && cls != last && run >= min_stripe_m) begin
                // First stripe only sets the reference class
                if (last != ST_NONE)
                    alt++;
                last = cls;
            end
        end
        return alt;
    endfunction

    function automatic void model_detect();
        int sum;
        int alt;
        sum     = 0;
        exp_det = 1'b0;
        for (int i = 0; i < 3; i++) begin
            alt = count_alts(cols[i]);
            sum += alt;
            if (alt >= min_alt_m)
                exp_det = 1'b1;
        end
        exp_cnt = sum / 3;
    endfunction

    // ====================
    // Frame generators
    // ====================

    function automatic void fill_random();
        for (int i = 0; i < NPIX; i++) begin
            pix_rng  = xorshift32(pix_rng);
            frame[i] = pix_rng[7:0];
        end
    endfunction

    // Bands three rows high, white on top
    function automatic void fill_bands();
        for (int i = 0; i < NPIX; i++)
            frame[i] = (((i / `IMG_WIDTH) / 3) % 2 == 0) ? 8'd255 : 8'd0;
    endfunction

    function automatic void fill_flat(input logic [7:0] value);
        for (int i = 0; i < NPIX; i++)
            frame[i] = value;
    endfunction

    // ====================
    // Checks and drivers
    // ====================

    task automatic check_value(input string name, input int idx, input int expv, input int actv);
        checks++;
        assert (expv == actv) else begin
            errors++;
            $display("Fail %s[%0d]: expected %0d, actual %0d", name, idx, expv, actv);
        end
    endtask

    // One-cycle write strobe, model registers follow
    task automatic write_reg(input cfg_addr_t addr, input logic [7:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
        case (addr)
            REG_SHIFT:      shift_m = data[2:0];
            REG_WHITE:      white_m = data;
            REG_BLACK:      black_m = data;
            REG_MIN_STRIPE: min_stripe_m = data;
            REG_MIN_ALT:    min_alt_m = data;
            default:        kern_m[int'(addr)] = $signed(data);
        endcase
    endtask

    // Centre tap one, all others zero, no output shift
    task automatic load_identity();
        for (int i = 0; i < 9; i++)
            write_reg(cfg_addr_t'(i), (i == 4) ? 8'd1 : 8'd0);
        write_reg(REG_SHIFT, 8'd0);
    endtask

    // Send the frame, then wait for every output and the frame result
    task automatic run_frame(input string name);
        model_filter();
        model_detect();
        got_q.delete();
        det_seen = 1'b0;
        for (int i = 0; i < NPIX; i++) begin
            x_valid = 1'b1;
            x_data  = frame[i];
            @(posedge clk);
            while (!x_ready)
                @(posedge clk);
            #2;
        end
        x_valid = 1'b0;
        while (got_q.size() < OUT_PIX || !det_seen)
            @(posedge clk);
        // Extra cycles expose duplicated pixels
        repeat (4) @(posedge clk);
        #2;
        check_value({name, "_count"}, 0, OUT_PIX, got_q.size());
        for (int i = 0; i < OUT_PIX && i < got_q.size(); i++)
            check_value(name, i, out_m[i], got_q[i]);
        check_value({name, "_detected"}, 0, exp_det, det_got);
        check_value({name, "_stripes"}, 0, exp_cnt, cnt_got);
    endtask

    // Random sink readiness when back-pressure is on
    always @(posedge clk) begin
        #2;
        if (bp_on) begin
            rdy_rng = xorshift32(rdy_rng);
            y_ready = rdy_rng[7];
        end else begin
            y_ready = 1'b1;
        end
    end

    // Output and result monitor
    always @(posedge clk) begin
        if (!rst && y_valid && y_ready)
            got_q.push_back(y_data);
        if (!rst && detection_valid) begin
            det_seen = 1'b1;
            det_got  = crossing_detected;
            cnt_got  = stripe_count;
        end
    end

    // Stalled output keeps its data
    always @(posedge clk) begin
        if (!rst && stall_q) begin
            assert (y_data == held_q) else begin
                errors++;
                $display("Fail stall_data: expected %0d, actual %0d", held_q, y_data);
            end
        end
        stall_q = y_valid && !y_ready && !rst;
        held_q  = y_data;
    end

    assert property (@(posedge clk) disable iff (rst) (y_valid && !y_ready) |=> y_valid)
        else begin
            errors++;
            $display("Fail stall_hold: expected y_valid 1, actual 0");
        end

    assert property (@(posedge clk) disable iff (rst) detection_valid |=> !detection_valid)
        else begin
            errors++;
            $display("Frame result pulse lasted longer than one cycle");
        end

    // ====================
    // Test sequence
    // ====================

    initial begin
        rst          = 1'b1;
        x_valid      = 1'b0;
        x_data       = '0;
        y_ready      = 1'b1;
        cfg_we       = 1'b0;
        cfg_addr     = REG_K0;
        cfg_wdata    = '0;
        kern_m       = sobel_k;
        shift_m      = `DEF_SHIFT;
        white_m      = `DEF_WHITE_THR;
        black_m      = `DEF_BLACK_THR;
        min_stripe_m = `DEF_MIN_STRIPE;
        min_alt_m    = `DEF_MIN_ALT;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle state right after reset
        check_value("reset_y_valid", 0, 0, y_valid);
        check_value("reset_detection_valid", 0, 0, detection_valid);
        check_value("reset_x_ready", 0, 1, x_ready);

        // Kernel and shift still at their reset values
        fill_random();
        run_frame("sobel");
        sobel_q = got_q;

        // Same frame again under random back-pressure
        bp_on = 1'b1;
        run_frame("backpressure");
        bp_on = 1'b0;
        for (int i = 0; i < OUT_PIX && i < got_q.size(); i++)
            check_value("backpressure_vs_sobel", i, sobel_q[i], got_q[i]);

        load_identity();
        fill_random();
        run_frame("passthrough");

        // Identity kernel stays in place for the stripe frames
        fill_bands();
        run_frame("zebra");
        zebra_cnt = exp_cnt;
        fill_flat(8'd128);
        run_frame("grey");

        // Raise the alternation floor above the zebra count
        fill_bands();
        write_reg(REG_MIN_ALT, 8'(zebra_cnt + 1));
        run_frame("min_alt");
        check_value("min_alt_unchanged_count", 0, zebra_cnt, cnt_got);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCH_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/zebra_pkg.sv
src/detect_config_regs.sv
src/convolution_filter.sv
src/zebra_crossing_detector_stream.sv
src/pattern_recognition.sv
test/tb_pattern_recognition.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pattern recognition testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"
verilator --binary --timing --assert -Wno-fatal \
    -f all.f \
    --top-module tb_pattern_recognition \
    --Mdir "$BUILD_DIR" -o sim

"./$BUILD_DIR/sim" | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi
echo "Testbench run clean"
